// File: src/decode_cfg.svh
// decode stage configuration
// data path width and register file geometry
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// data path and instruction width
`define DEC_WORD_W 16

// general registers and the width of a register index
`define DEC_REG_CNT 8
`define DEC_REG_AW 3

`endif

// File: src/isa_pkg.sv
// instruction-set types for the 16-bit processor
// opcode, ALU, extension and branch encodings plus the decoded control word
package isa_pkg;

   // major opcode, instruction bits 15..11
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100,
      OP_JR    = 5'b00101,
      OP_JAL   = 5'b00110,
      OP_JALR  = 5'b00111,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_BLTZ  = 5'b01110,
      OP_BGEZ  = 5'b01111,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_STU   = 5'b10011,
      OP_ALU_R = 5'b11011,
      OP_LBI   = 5'b11000
   } opcode_e;

   // operation for the execute stage
   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_XOR    = 4'd2,
      ALU_ANDN   = 4'd3,
      ALU_PASS_B = 4'd4
   } alu_op_e;

   // immediate field select
   typedef enum logic [1:0] {
      EXT_IMM5   = 2'd0,
      EXT_IMM8   = 2'd1,
      EXT_DISP11 = 2'd2
   } ext_op_e;

   typedef enum logic [2:0] {
      BJ_NONE = 3'd0,
      BJ_BEQZ = 3'd1,
      BJ_BNEZ = 3'd2,
      BJ_BLTZ = 3'd3,
      BJ_BGEZ = 3'd4,
      BJ_J    = 3'd5,
      BJ_JR   = 3'd6
   } bj_op_e;

   // all zero is a NOP
   typedef struct packed {
      alu_op_e alu_op;
      logic    alu_src;
      ext_op_e ext_op;
      logic    ext_sign;
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    mem_to_reg;
      bj_op_e  bj_op;
      logic    link;
      logic    halt;
      logic    illegal;
      logic    uses_rs;
      logic    uses_rt;
   } ctrl_t;

endpackage

// File: src/pipe_pkg.sv
// pipeline-side types seen by the decode stage
// destination info of instructions in flight and the writeback port
`include "decode_cfg.svh"

package pipe_pkg;

   // one later stage, as far as hazard checking cares
   typedef struct packed {
      logic                   reg_write;
      logic [`DEC_REG_AW-1:0] dest;
   } stage_info_t;

   // writeback data arrives already selected (alu, load or link)
   typedef struct packed {
      logic                   reg_write;
      logic [`DEC_REG_AW-1:0] dest;
      logic [`DEC_WORD_W-1:0] data;
   } wb_t;

endpackage

// File: src/control_decode.sv
// main decoder of the decode stage
// maps the opcode to the control word and picks the destination register
`timescale 1ns/1ps
`include "decode_cfg.svh"

module control_decode (
   input  logic [`DEC_WORD_W-1:0] inst,
   input  logic                   inst_valid,
   output isa_pkg::ctrl_t         ctrl,
   output logic [`DEC_REG_AW-1:0] dest
);
   import isa_pkg::*;

   // JAL and JALR link into the top register
   localparam logic [`DEC_REG_AW-1:0] LINK_REG = '1;

   opcode_e                opcode;
   logic [`DEC_REG_AW-1:0] rs_f;
   logic [`DEC_REG_AW-1:0] rt_f;
   logic [`DEC_REG_AW-1:0] rd_f;

   assign opcode = opcode_e'(inst[15:11]);
   assign rs_f   = inst[10:8];
   assign rt_f   = inst[7:5];
   assign rd_f   = inst[4:2];

   always_comb begin
      ctrl = '0;
      dest = '0;
      if (inst_valid) begin
         case (opcode)
            OP_HALT: ctrl.halt = 1'b1;
            OP_NOP: ctrl.halt = 1'b0;
            OP_ALU_R: begin
               ctrl.reg_write = 1'b1;
               ctrl.uses_rs   = 1'b1;
               ctrl.uses_rt   = 1'b1;
               dest           = rd_f;
               // function code in bits 1..0
               case (inst[1:0])
                  2'b00: ctrl.alu_op = ALU_ADD;
                  2'b01: ctrl.alu_op = ALU_SUB;
                  2'b10: ctrl.alu_op = ALU_XOR;
                  default: ctrl.alu_op = ALU_ANDN;
               endcase
            end
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
               ctrl.alu_src   = 1'b1;
               ctrl.ext_op    = EXT_IMM5;
               // logic ops take the field unsigned
               ctrl.ext_sign  = (opcode == OP_ADDI) || (opcode == OP_SUBI);
               ctrl.reg_write = 1'b1;
               ctrl.uses_rs   = 1'b1;
               dest           = rt_f;
               case (opcode)
                  OP_SUBI: ctrl.alu_op = ALU_SUB;
                  OP_XORI: ctrl.alu_op = ALU_XOR;
                  OP_ANDNI: ctrl.alu_op = ALU_ANDN;
                  default: ctrl.alu_op = ALU_ADD;
               endcase
            end
            OP_ST, OP_LD, OP_STU: begin
               ctrl.alu_src  = 1'b1;
               ctrl.ext_op   = EXT_IMM5;
               ctrl.ext_sign = 1'b1;
               ctrl.uses_rs  = 1'b1;
               if (opcode == OP_LD) begin
                  ctrl.mem_read   = 1'b1;
                  ctrl.mem_to_reg = 1'b1;
                  ctrl.reg_write  = 1'b1;
                  dest            = rt_f;
               end else begin
                  // stores read rt as the data to write
                  ctrl.mem_write = 1'b1;
                  ctrl.uses_rt   = 1'b1;
                  // store with update writes the address back into rs
                  ctrl.reg_write = (opcode == OP_STU);
                  dest           = (opcode == OP_STU) ? rs_f : '0;
               end
            end
            OP_LBI: begin
               ctrl.alu_op    = ALU_PASS_B;
               ctrl.alu_src   = 1'b1;
               ctrl.ext_op    = EXT_IMM8;
               ctrl.ext_sign  = 1'b1;
               ctrl.reg_write = 1'b1;
               dest           = rs_f;
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
               ctrl.ext_op   = EXT_IMM8;
               ctrl.ext_sign = 1'b1;
               ctrl.uses_rs  = 1'b1;
               case (opcode)
                  OP_BEQZ: ctrl.bj_op = BJ_BEQZ;
                  OP_BNEZ: ctrl.bj_op = BJ_BNEZ;
                  OP_BLTZ: ctrl.bj_op = BJ_BLTZ;
                  default: ctrl.bj_op = BJ_BGEZ;
               endcase
            end
            OP_J, OP_JAL: begin
               ctrl.ext_op    = EXT_DISP11;
               ctrl.ext_sign  = 1'b1;
               ctrl.bj_op     = BJ_J;
               ctrl.link      = (opcode == OP_JAL);
               ctrl.reg_write = (opcode == OP_JAL);
               dest           = (opcode == OP_JAL) ? LINK_REG : '0;
            end
            OP_JR, OP_JALR: begin
               ctrl.ext_op    = EXT_IMM8;
               ctrl.ext_sign  = 1'b1;
               ctrl.bj_op     = BJ_JR;
               ctrl.uses_rs   = 1'b1;
               ctrl.link      = (opcode == OP_JALR);
               ctrl.reg_write = (opcode == OP_JALR);
               dest           = (opcode == OP_JALR) ? LINK_REG : '0;
            end
            // undefined code, every enable stays clear
            default: ctrl.illegal = 1'b1;
         endcase
      end
   end

endmodule

// File: src/reg_file_bypass.sv
// general register file, two read ports and one write port
// a read of the index being written returns the writeback data directly
`timescale 1ns/1ps
`include "decode_cfg.svh"

module reg_file_bypass #(
   parameter int REG_CNT = `DEC_REG_CNT
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [`DEC_REG_AW-1:0] rs_sel,
   input  logic [`DEC_REG_AW-1:0] rt_sel,
   input  pipe_pkg::wb_t          wb,
   output logic [`DEC_WORD_W-1:0] rs_data,
   output logic [`DEC_WORD_W-1:0] rt_data
);

   logic [`DEC_WORD_W-1:0] regs [REG_CNT];
   logic                   rs_hit;
   logic                   rt_hit;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.reg_write) begin
         regs[wb.dest] <= wb.data;
      end
   end

   // same-cycle write to a read index
   assign rs_hit = wb.reg_write && (wb.dest == rs_sel);
   assign rt_hit = wb.reg_write && (wb.dest == rt_sel);

   assign rs_data = rs_hit ? wb.data : regs[rs_sel];
   assign rt_data = rt_hit ? wb.data : regs[rt_sel];

endmodule

// File: src/imm_extend.sv
// immediate builder, selects the 5, 8 or 11 bit field of the instruction
// and zero- or sign-extends it to the word width
`timescale 1ns/1ps
`include "decode_cfg.svh"

module imm_extend (
   input  logic [`DEC_WORD_W-1:0] inst,
   input  isa_pkg::ext_op_e       ext_op,
   input  logic                   ext_sign,
   output logic [`DEC_WORD_W-1:0] imm
);
   import isa_pkg::*;

   always_comb begin
      case (ext_op)
         EXT_IMM8: imm = {{(`DEC_WORD_W-8){ext_sign & inst[7]}}, inst[7:0]};
         EXT_DISP11: imm = {{(`DEC_WORD_W-11){ext_sign & inst[10]}}, inst[10:0]};
         // IMM5 and the unused code
         default: imm = {{(`DEC_WORD_W-5){ext_sign & inst[4]}}, inst[4:0]};
      endcase
   end

endmodule

// File: src/branch_target.sv
// branch and jump resolution in decode
// condition on rs, target address and the link value for JAL/JALR
`timescale 1ns/1ps
`include "decode_cfg.svh"

module branch_target (
   input  logic [`DEC_WORD_W-1:0] pc,
   input  logic [`DEC_WORD_W-1:0] rs_data,
   input  logic [`DEC_WORD_W-1:0] imm,
   input  isa_pkg::bj_op_e        bj_op,
   output logic [`DEC_WORD_W-1:0] target,
   output logic                   redirect,
   output logic [`DEC_WORD_W-1:0] link_data
);
   import isa_pkg::*;

   logic rs_zero;
   logic rs_neg;

   // pc of the next sequential instruction
   assign link_data = pc + `DEC_WORD_W'(2);

   assign rs_zero = (rs_data == '0);
   assign rs_neg  = rs_data[`DEC_WORD_W-1];

   // only JR/JALR take a register base
   assign target = (bj_op == BJ_JR) ? rs_data + imm : link_data + imm;

   always_comb begin
      case (bj_op)
         BJ_BEQZ: redirect = rs_zero;
         BJ_BNEZ: redirect = !rs_zero;
         BJ_BLTZ: redirect = rs_neg;
         BJ_BGEZ: redirect = !rs_neg;
         BJ_J, BJ_JR: redirect = 1'b1;
         default: redirect = 1'b0;
      endcase
   end

endmodule

// File: src/hazard_detect.sv
// RAW hazard check of the decoded sources against the three stages ahead
// stalls decode and holds back the fetch flush while an operand is stale
`timescale 1ns/1ps
`include "decode_cfg.svh"

module hazard_detect (
   input  logic [`DEC_WORD_W-1:0] inst,
   input  logic [1:0]             ctrl_uses,
   input  logic                   redirect,
   input  pipe_pkg::stage_info_t  id_ex,
   input  pipe_pkg::stage_info_t  ex_mem,
   input  pipe_pkg::stage_info_t  mem_wb,
   output logic                   stall_decode,
   output logic                   flush_fetch
);
   import pipe_pkg::*;

   logic [`DEC_REG_AW-1:0] rs_f;
   logic [`DEC_REG_AW-1:0] rt_f;
   logic                   rs_hit;
   logic                   rt_hit;

   // one stage about to write the given register
   function automatic logic writes_to(input stage_info_t st,
                                      input logic [`DEC_REG_AW-1:0] sel);
      return st.reg_write && (st.dest == sel);
   endfunction

   assign rs_f = inst[10:8];
   assign rt_f = inst[7:5];

   // ctrl_uses is {uses_rs, uses_rt}, both low for a NOP
   assign rs_hit = ctrl_uses[1] &&
                   (writes_to(id_ex, rs_f) || writes_to(ex_mem, rs_f) ||
                    writes_to(mem_wb, rs_f));
   assign rt_hit = ctrl_uses[0] &&
                   (writes_to(id_ex, rt_f) || writes_to(ex_mem, rt_f) ||
                    writes_to(mem_wb, rt_f));

   assign stall_decode = rs_hit || rt_hit;

   // the branch decision may rest on a stale rs, so wait for the stall to clear
   assign flush_fetch = redirect && !stall_decode;

endmodule

// File: src/decode_stage.sv
// instruction decode stage of the five-stage pipeline
// control, register read with bypass, immediate, branch resolution, hazards
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [`DEC_WORD_W-1:0] inst,
   input  logic                   inst_valid,
   input  logic [`DEC_WORD_W-1:0] pc,
   input  pipe_pkg::wb_t          wb,
   input  pipe_pkg::stage_info_t  id_ex,
   input  pipe_pkg::stage_info_t  ex_mem,
   input  pipe_pkg::stage_info_t  mem_wb,
   output isa_pkg::ctrl_t         ctrl,
   output logic [`DEC_REG_AW-1:0] dest,
   output logic [`DEC_WORD_W-1:0] rs_data,
   output logic [`DEC_WORD_W-1:0] rt_data,
   output logic [`DEC_WORD_W-1:0] imm,
   output logic [`DEC_WORD_W-1:0] target,
   output logic [`DEC_WORD_W-1:0] link_data,
   output logic                   redirect,
   output logic                   stall_decode,
   output logic                   flush_fetch,
   output logic                   err
);

   logic [1:0] ctrl_uses;

   control_decode u_control (
      .inst       (inst),
      .inst_valid (inst_valid),
      .ctrl       (ctrl),
      .dest       (dest)
   );

   // rs is bits 10..8, rt is bits 7..5
   reg_file_bypass u_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .rs_sel  (inst[10:8]),
      .rt_sel  (inst[7:5]),
      .wb      (wb),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   imm_extend u_imm (
      .inst     (inst),
      .ext_op   (ctrl.ext_op),
      .ext_sign (ctrl.ext_sign),
      .imm      (imm)
   );

   branch_target u_branch (
      .pc        (pc),
      .rs_data   (rs_data),
      .imm       (imm),
      .bj_op     (ctrl.bj_op),
      .target    (target),
      .redirect  (redirect),
      .link_data (link_data)
   );

   assign ctrl_uses = {ctrl.uses_rs, ctrl.uses_rt};

   hazard_detect u_hazard (
      .inst         (inst),
      .ctrl_uses    (ctrl_uses),
      .redirect     (redirect),
      .id_ex        (id_ex),
      .ex_mem       (ex_mem),
      .mem_wb       (mem_wb),
      .stall_decode (stall_decode),
      .flush_fetch  (flush_fetch)
   );

   // only fault reported from decode
   assign err = ctrl.illegal;

endmodule

// File: bench/decode_stage_tb.sv
// testbench for the instruction decode stage
// random and directed instructions checked against a register model and the ISA rules
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage_tb;
   import isa_pkg::*;
   import pipe_pkg::*;

   localparam int W = `DEC_WORD_W;
   localparam int RAND_CYCLES = 200;
   // reset, index sweep, three random tests, preload, branch sweep, stall case, opcode sweep
   localparam int MAX_CYCLES = 2 * (3 + 8 + 3 * RAND_CYCLES + 8 + 64 + 1 + 32);

   logic                   clk;
   logic                   rst_n;
   logic [W-1:0]           inst;
   logic                   inst_valid;
   logic [W-1:0]           pc;
   wb_t                    wb;
   stage_info_t            id_ex;
   stage_info_t            ex_mem;
   stage_info_t            mem_wb;
   ctrl_t                  ctrl;
   logic [`DEC_REG_AW-1:0] dest;
   logic [W-1:0]           rs_data;
   logic [W-1:0]           rt_data;
   logic [W-1:0]           imm;
   logic [W-1:0]           target;
   logic [W-1:0]           link_data;
   logic                   redirect;
   logic                   stall_decode;
   logic                   flush_fetch;
   logic                   err;

   logic [W-1:0] model [`DEC_REG_CNT];
   logic [31:0]  lcg_state = 32'h3300_b9c7;
   int           cycles = 0;
   int           errors = 0;
   int           tests_passed = 0;
   int           tests_failed = 0;

   opcode_e legal_ops [19] = '{OP_HALT, OP_NOP, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_ST,
                               OP_LD, OP_STU, OP_LBI, OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ,
                               OP_J, OP_JR, OP_JAL, OP_JALR, OP_ALU_R};
   opcode_e bj_ops [8] = '{OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ, OP_J, OP_JR, OP_JAL, OP_JALR};
   // zero, positive and negative values, with the sign boundary on both sides
   logic [W-1:0] preload [8] = '{16'h0000, 16'h0005, 16'hfffd, 16'h8000,
                                 16'h7fff, 16'h0000, 16'h0001, 16'hff00};

   decode_stage uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .inst         (inst),
      .inst_valid   (inst_valid),
      .pc           (pc),
      .wb           (wb),
      .id_ex        (id_ex),
      .ex_mem       (ex_mem),
      .mem_wb       (mem_wb),
      .ctrl         (ctrl),
      .dest         (dest),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .imm          (imm),
      .target       (target),
      .link_data    (link_data),
      .redirect     (redirect),
      .stall_decode (stall_decode),
      .flush_fetch  (flush_fetch),
      .err          (err)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // linear congruential generator, upper half of the state
   function automatic logic [15:0] rand16();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   function automatic wb_t make_wb(input logic we, input logic [2:0] d, input logic [W-1:0] v);
      return '{reg_write: we, dest: d, data: v};
   endfunction

   function automatic stage_info_t make_st(input logic we, input logic [2:0] d);
      return '{reg_write: we, dest: d};
   endfunction

   function automatic logic is_legal(input opcode_e op);
      foreach (legal_ops[k]) begin
         if (legal_ops[k] == op) return 1'b1;
      end
      return 1'b0;
   endfunction

   function automatic logic writes_reg(input opcode_e op);
      case (op)
         OP_ALU_R, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_LD, OP_LBI, OP_STU,
         OP_JAL, OP_JALR: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic [2:0] exp_dest(input opcode_e op, input logic [W-1:0] i);
      case (op)
         OP_ALU_R: return i[4:2];
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_LD: return i[7:5];
         OP_LBI, OP_STU: return i[10:8];
         OP_JAL, OP_JALR: return 3'd7;
         default: return 3'd0;
      endcase
   endfunction

   function automatic logic uses_rs(input opcode_e op);
      case (op)
         OP_ALU_R, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_ST, OP_LD, OP_STU,
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ, OP_JR, OP_JALR: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic uses_rt(input opcode_e op);
      return (op == OP_ALU_R) || (op == OP_ST) || (op == OP_STU);
   endfunction

   // HALT, NOP and ALU_R carry no immediate
   function automatic logic has_imm(input opcode_e op);
      return is_legal(op) && (op != OP_HALT) && (op != OP_NOP) && (op != OP_ALU_R);
   endfunction

   function automatic logic [W-1:0] exp_imm(input opcode_e op, input logic [W-1:0] i);
      case (op)
         OP_XORI, OP_ANDNI: return {{(W-5){1'b0}}, i[4:0]};
         OP_ADDI, OP_SUBI, OP_ST, OP_LD, OP_STU: return {{(W-5){i[4]}}, i[4:0]};
         OP_J, OP_JAL: return {{(W-11){i[10]}}, i[10:0]};
         default: return {{(W-8){i[7]}}, i[7:0]};
      endcase
   endfunction

   function automatic logic exp_redirect(input opcode_e op, input logic [W-1:0] rsv);
      case (op)
         OP_BEQZ: return rsv == '0;
         OP_BNEZ: return rsv != '0;
         OP_BLTZ: return rsv[W-1];
         OP_BGEZ: return !rsv[W-1];
         OP_J, OP_JAL, OP_JR, OP_JALR: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic in_flight(input logic [2:0] r);
      return (id_ex.reg_write && id_ex.dest == r) || (ex_mem.reg_write && ex_mem.dest == r) ||
             (mem_wb.reg_write && mem_wb.dest == r);
   endfunction

   // wide enough for the whole control word
   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
   endtask

   task automatic check_outputs();
      opcode_e      op;
      logic [W-1:0] exp_rs;
      logic [W-1:0] exp_rt;
      logic [W-1:0] exp_tgt;
      logic         exp_redir;
      logic         exp_stall;
      op = inst_valid ? opcode_e'(inst[15:11]) : OP_NOP;
      exp_rs = (wb.reg_write && wb.dest == inst[10:8]) ? wb.data : model[inst[10:8]];
      exp_rt = (wb.reg_write && wb.dest == inst[7:5]) ? wb.data : model[inst[7:5]];
      exp_redir = exp_redirect(op, exp_rs);
      exp_tgt = (op == OP_JR || op == OP_JALR) ? exp_rs + exp_imm(op, inst) :
                pc + W'(2) + exp_imm(op, inst);
      exp_stall = (uses_rs(op) && in_flight(inst[10:8])) ||
                  (uses_rt(op) && in_flight(inst[7:5]));
      assert (rs_data === exp_rs) else report_mismatch("rs_data", rs_data, exp_rs);
      assert (rt_data === exp_rt) else report_mismatch("rt_data", rt_data, exp_rt);
      assert (dest === exp_dest(op, inst)) else report_mismatch("dest", dest, exp_dest(op, inst));
      assert (ctrl.reg_write === writes_reg(op))
         else report_mismatch("reg_write", ctrl.reg_write, writes_reg(op));
      assert (ctrl.mem_write === (op == OP_ST || op == OP_STU))
         else report_mismatch("mem_write", ctrl.mem_write, op == OP_ST || op == OP_STU);
      assert (err === !is_legal(op)) else report_mismatch("err", err, !is_legal(op));
      if (!is_legal(op)) begin
         assert (ctrl.mem_read === 1'b0) else report_mismatch("mem_read", ctrl.mem_read, 0);
      end
      if (!inst_valid) begin
         assert (ctrl === '0) else report_mismatch("ctrl while idle", 32'(ctrl), 0);
      end
      if (has_imm(op)) begin
         assert (imm === exp_imm(op, inst)) else report_mismatch("imm", imm, exp_imm(op, inst));
      end
      assert (link_data === pc + W'(2)) else report_mismatch("link_data", link_data, pc + W'(2));
      assert (redirect === exp_redir) else report_mismatch("redirect", redirect, exp_redir);
      if (exp_redir) begin
         assert (target === exp_tgt) else report_mismatch("target", target, exp_tgt);
      end
      assert (stall_decode === exp_stall)
         else report_mismatch("stall_decode", stall_decode, exp_stall);
      assert (flush_fetch === (exp_redir && !exp_stall))
         else report_mismatch("flush_fetch", flush_fetch, exp_redir && !exp_stall);
   endtask

   // drive one cycle at the rising edge, check at the falling edge, then follow the write
   task automatic apply_cycle(input logic [W-1:0] i, input logic v, input logic [W-1:0] p,
                              input wb_t w, input stage_info_t a, input stage_info_t b,
                              input stage_info_t c);
      @(posedge clk);
      inst       <= i;
      inst_valid <= v;
      pc         <= p;
      wb         <= w;
      id_ex      <= a;
      ex_mem     <= b;
      mem_wb     <= c;
      @(negedge clk);
      check_outputs();
      if (w.reg_write) model[w.dest] = w.data;
   endtask

   task automatic close_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         tests_passed++;
         $display("test %s: passed", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - errors_before);
      end
   endtask

   initial begin
      logic [W-1:0] r;
      logic [W-1:0] r2;
      logic [W-1:0] p;
      int           start;
      clk        = 1'b0;
      rst_n      = 1'b0;
      inst       = '0;
      inst_valid = 1'b0;
      pc         = '0;
      wb         = '0;
      id_ex      = '0;
      ex_mem     = '0;
      mem_wb     = '0;
      foreach (model[k]) model[k] = '0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      start = errors;
      for (int k = 0; k < 8; k++) begin
         apply_cycle({5'd0, 3'(k), 3'(7 - k), 5'd0}, 1'b0, '0, '0, '0, '0, '0);
      end
      close_test("reset and idle", start);

      start = errors;
      for (int k = 0; k < RAND_CYCLES; k++) begin
         r  = rand16();
         r2 = rand16();
         p  = rand16();
         // every other write lands on the rs index being read
         apply_cycle({OP_NOP, r[4] ? r[3:1] : p[10:8], p[7:0]}, p[15], p,
                     make_wb(r[0], r[3:1], r2), '0, '0, '0);
      end
      close_test("register write and bypass", start);

      start = errors;
      for (int k = 0; k < RAND_CYCLES; k++) begin
         r = rand16();
         p = rand16();
         apply_cycle({legal_ops[rand16() % 19], r[10:0]}, 1'b1, p, '0, '0, '0, '0);
      end
      close_test("decode and immediate", start);

      start = errors;
      for (int k = 0; k < 8; k++) begin
         apply_cycle('0, 1'b0, '0, make_wb(1'b1, 3'(k), preload[k]), '0, '0, '0);
      end
      foreach (bj_ops[b]) begin
         for (int k = 0; k < 8; k++) begin
            r = rand16();
            p = rand16();
            apply_cycle({bj_ops[b], 3'(k), r[7:0]}, 1'b1, p, '0, '0, '0, '0);
         end
      end
      close_test("branches and jumps", start);

      start = errors;
      for (int k = 0; k < RAND_CYCLES; k++) begin
         r  = rand16();
         r2 = rand16();
         apply_cycle({legal_ops[rand16() % 19], r[10:0]}, 1'b1, rand16(), '0,
                     make_st(r2[0], r2[3:1]), make_st(r2[4], r2[7:5]),
                     make_st(r2[8], r2[11:9]));
      end
      // r0 holds zero, so BEQZ is taken while id_ex is about to write r0
      apply_cycle({OP_BEQZ, 3'd0, 8'h10}, 1'b1, 16'h0200, '0, make_st(1'b1, 3'd0), '0, '0);
      assert (redirect && stall_decode && !flush_fetch) else begin
         $display("taken branch under a stall did not hold back the fetch flush");
         errors++;
      end
      close_test("hazards", start);

      start = errors;
      for (int k = 0; k < 32; k++) begin
         if (!is_legal(opcode_e'(5'(k)))) begin
            r = rand16();
            apply_cycle({5'(k), r[10:0]}, 1'b1, rand16(), '0, '0, '0, '0);
         end
      end
      close_test("illegal opcodes", start);

      $display("tests passed %0d, tests failed %0d, failed checks %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/control_decode.sv
src/reg_file_bypass.sv
src/imm_extend.sv
src/branch_target.sv
src/hazard_detect.sv
src/decode_stage.sv
bench/decode_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --assert -Wno-fatal -f sim.f --top-module decode_stage_tb \
   -o decode_stage_sim > build.log 2>&1 \
   && ./obj_dir/decode_stage_sim > sim.log 2>&1 \
   || { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "^RESULT: PASS$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
